// File: src.f
hw/rv_pkg.sv
hw/instr_decoder.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_counter.sv
hw/control_fsm.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/riscv_core.sv
tests/riscv_core_sva.sv
tests/riscv_core_tb.sv

// File: tests/riscv_core_tb.sv
module riscv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'he49a4741;

    logic        clk;
    logic        rst;
    logic        start;
    logic        load_en;
    logic [5:0]  load_addr;
    logic [31:0] load_data;
    logic        halted;
    logic        retire;
    logic        retire_we;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    // program table, one row per instruction word
    logic [31:0] tbl_instr [64];
    logic        tbl_live  [64];    // the row is expected to retire
    logic        tbl_we    [64];
    logic [4:0]  tbl_rd    [64];
    logic [31:0] tbl_value [64];
    int          n_rows;

    // architectural model that fills the expected columns
    logic [31:0] mdl_regs [32];
    logic [31:0] mdl_mem  [64];
    logic [31:0] mdl_pc;

    logic [31:0] lfsr_state;
    int          n_value_errors = 0;
    int          n_other = 0;
    int          cycle_limit = 200;    // margin for resets, loads and idle windows
    int          cycles = 0;

    riscv_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .halted       (halted),
        .retire       (retire),
        .retire_we    (retire_we),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = 32'b0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I result by funct3, sub selects the funct7 variant of 000
    function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic sub,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            n_value_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 32; i++)
            mdl_regs[i] = 32'b0;
        mdl_pc = 32'b0;
        n_rows = 0;
    endtask

    task automatic push_row(input logic [31:0] instr, input logic retires, input logic we,
                            input logic [4:0] rd, input logic [31:0] value,
                            input logic [31:0] next_pc);
        logic reached;
        reached = (n_rows * 4 == mdl_pc);    // rows jumped over never execute in the model
        tbl_instr[n_rows] = instr;
        tbl_live[n_rows]  = reached && retires;
        tbl_we[n_rows]    = we;
        tbl_rd[n_rows]    = rd;
        tbl_value[n_rows] = value;
        if (reached && we && rd != 5'd0)
            mdl_regs[rd] = value;
        if (reached)
            mdl_pc = next_pc;
        n_rows++;
    endtask

    // ==============================
    // instruction emitters
    // ==============================
    task automatic emit_r(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] v;
        v = alu_rule(f3, sub, mdl_regs[rs1], mdl_regs[rs2]);
        push_row({1'b0, sub, 5'b0, rs2, rs1, f3, rd, rv_pkg::OP_R}, 1'b1, 1'b1, rd, v,
                 mdl_pc + 32'd4);
    endtask

    task automatic emit_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        logic [31:0] v;
        v = alu_rule(f3, 1'b0, mdl_regs[rs1], sext12(imm));
        push_row({imm, rs1, f3, rd, rv_pkg::OP_IMM}, 1'b1, 1'b1, rd, v, mdl_pc + 32'd4);
    endtask

    task automatic emit_lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = mdl_regs[rs1] + sext12(imm);
        push_row({imm, rs1, 3'b010, rd, rv_pkg::OP_LOAD}, 1'b1, 1'b1, rd, mdl_mem[addr[7:2]],
                 mdl_pc + 32'd4);
    endtask

    task automatic emit_sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = mdl_regs[rs1] + sext12(imm);
        if (n_rows * 4 == mdl_pc)
            mdl_mem[addr[7:2]] = mdl_regs[rs2];
        push_row({imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE}, 1'b1, 1'b0, 5'd0,
                 32'b0, mdl_pc + 32'd4);
    endtask

    task automatic emit_branch(input logic ne, input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [12:0] off);
        logic taken;
        taken = (mdl_regs[rs1] == mdl_regs[rs2]) ^ ne;
        push_row({off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11],
                  rv_pkg::OP_BRANCH}, 1'b1, 1'b0, 5'd0, 32'b0,
                 taken ? mdl_pc + {{19{off[12]}}, off} : mdl_pc + 32'd4);
    endtask

    task automatic emit_jal(input logic [4:0] rd, input logic [20:0] off);
        push_row({off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL}, 1'b1, 1'b1, rd,
                 mdl_pc + 32'd4, mdl_pc + {{11{off[20]}}, off});
    endtask

    task automatic emit_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        push_row({imm, rs1, 3'b000, rd, rv_pkg::OP_JALR}, 1'b1, 1'b1, rd, mdl_pc + 32'd4,
                 (mdl_regs[rs1] + sext12(imm)) & ~32'd1);
    endtask

    task automatic emit_lui(input logic [4:0] rd, input logic [19:0] imm);
        push_row({imm, rd, rv_pkg::OP_LUI}, 1'b1, 1'b1, rd, {imm, 12'b0}, mdl_pc + 32'd4);
    endtask

    task automatic emit_ecall();
        push_row(32'h00000073, 1'b0, 1'b0, 5'd0, 32'b0, mdl_pc);
    endtask

    // ==============================
    // programs
    // ==============================
    task automatic build_program_one();
        logic [31:0] r;
        reset_model();
        for (int i = 1; i <= 3; i++)
        begin
            draw_bits(12, r);
            emit_imm(3'd0, i[4:0], 5'd0, r[11:0]);
        end
        draw_bits(5, r);
        emit_imm(3'd0, 5'd4, 5'd0, r[11:0]);      // shift amount for sll and srl
        emit_r(3'd0, 1'b0, 5'd5, 5'd1, 5'd2);
        emit_r(3'd0, 1'b1, 5'd6, 5'd1, 5'd2);
        emit_r(3'd7, 1'b0, 5'd7, 5'd1, 5'd3);
        emit_r(3'd6, 1'b0, 5'd8, 5'd2, 5'd3);
        emit_r(3'd4, 1'b0, 5'd9, 5'd1, 5'd3);
        emit_r(3'd2, 1'b0, 5'd10, 5'd1, 5'd2);
        emit_r(3'd2, 1'b0, 5'd11, 5'd2, 5'd1);
        emit_r(3'd1, 1'b0, 5'd12, 5'd1, 5'd4);
        emit_r(3'd5, 1'b0, 5'd13, 5'd1, 5'd4);
        emit_imm(3'd0, 5'd0, 5'd1, 12'd7);        // x0 retires a value but keeps zero
        emit_r(3'd0, 1'b0, 5'd14, 5'd0, 5'd5);
        draw_bits(12, r);
        emit_imm(3'd6, 5'd16, 5'd2, r[11:0]);
        emit_imm(3'd7, 5'd17, 5'd3, r[11:0]);
        emit_imm(3'd4, 5'd18, 5'd1, r[11:0]);
        emit_imm(3'd2, 5'd19, 5'd1, r[11:0]);
        emit_sw(5'd5, 5'd0, 12'h040);
        emit_lw(5'd15, 5'd0, 12'h040);
        emit_branch(1'b0, 5'd1, 5'd1, 13'd8);
        emit_imm(3'd0, 5'd20, 5'd0, 12'd1);
        emit_branch(1'b0, 5'd1, 5'd2, 13'd8);
        emit_imm(3'd0, 5'd20, 5'd0, 12'd2);
        emit_branch(1'b1, 5'd1, 5'd2, 13'd8);
        emit_imm(3'd0, 5'd21, 5'd0, 12'd3);
        emit_branch(1'b1, 5'd1, 5'd1, 13'd8);
        emit_imm(3'd0, 5'd21, 5'd0, 12'd4);
        emit_jal(5'd22, 21'd8);
        emit_imm(3'd0, 5'd23, 5'd0, 12'd5);
        emit_jalr(5'd24, 5'd22, 12'd12);          // lands just past the next word
        emit_imm(3'd0, 5'd25, 5'd0, 12'd6);
        draw_bits(20, r);
        emit_lui(5'd26, r[19:0]);
        emit_ecall();
    endtask

    task automatic build_program_two();
        logic [31:0] r;
        reset_model();
        draw_bits(12, r);
        emit_imm(3'd0, 5'd1, 5'd0, r[11:0]);
        draw_bits(12, r);
        emit_imm(3'd0, 5'd2, 5'd1, r[11:0]);
        emit_r(3'd0, 1'b1, 5'd3, 5'd2, 5'd1);
        emit_r(3'd4, 1'b0, 5'd4, 5'd1, 5'd2);
        draw_bits(20, r);
        emit_lui(5'd5, r[19:0]);
        emit_ecall();
    endtask

    // ==============================
    // stimulus and checks
    // ==============================
    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_field("retire", {31'b0, retire}, 32'b0);
        compare_field("halted", {31'b0, halted}, 32'b0);
    endtask

    task automatic load_program();
        for (int i = 0; i < n_rows; i++)
        begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = 6'(i);
            load_data = tbl_instr[i];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_retire(output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 12)
        begin
            @(negedge clk);
            n++;
            seen = retire;
        end
    endtask

    task automatic run_checks();
        logic seen;
        int   extra;
        int   n;
        for (int row = 0; row < n_rows; row++)
        begin
            if (tbl_live[row])
            begin
                wait_retire(seen);
                assert (seen)
                else
                begin
                    n_other++;
                    $display("no retire came for the instruction at pc %0h", row * 4);
                end
                if (seen)
                begin
                    compare_field("retire_pc", retire_pc, row * 4);
                    compare_field("retire_we", {31'b0, retire_we}, {31'b0, tbl_we[row]});
                    if (tbl_we[row])
                    begin
                        compare_field("retire_rd", {27'b0, retire_rd}, {27'b0, tbl_rd[row]});
                        compare_field("retire_value", retire_value, tbl_value[row]);
                    end
                end
            end
        end
        // ecall must halt the core without another retire
        extra = 0;
        n = 0;
        while (!halted && n < 10)
        begin
            @(negedge clk);
            n++;
            if (retire)
                extra++;
        end
        assert (halted)
        else
        begin
            n_other++;
            $display("the core did not halt after ecall");
        end
        repeat (8)
        begin
            @(negedge clk);
            if (retire)
                extra++;
        end
        assert (extra == 0)
        else
        begin
            n_other++;
            $display("the core retired %0d instructions past the end of the program", extra);
        end
    endtask

    task automatic confirm_ignored();
        int extra;
        int dropped;
        extra = 0;
        dropped = 0;
        repeat (10)
        begin
            @(negedge clk);
            if (retire)
                extra++;
            if (!halted)
                dropped++;
        end
        assert (extra == 0 && dropped == 0)
        else
        begin
            n_other++;
            $display("a start while halted ran the core before any reset");
        end
    endtask

    // ends the run once the cycle budget of the built programs is used up
    initial
    begin
        while (cycles <= cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run went past %0d clock cycles", cycle_limit);
        $display("tests failed");
        $finish;
    end

    initial
    begin
        int total;
        rst        = 1'b1;
        start      = 1'b0;
        load_en    = 1'b0;
        load_addr  = 6'd0;
        load_data  = 32'b0;
        lfsr_state = SEED;

        apply_reset();
        build_program_one();
        cycle_limit += 6 * n_rows;
        load_program();
        pulse_start();
        run_checks();

        // the second program goes in while halted and must wait for a reset
        build_program_two();
        cycle_limit += 6 * n_rows;
        load_program();
        pulse_start();
        confirm_ignored();
        apply_reset();
        pulse_start();
        run_checks();

        total = n_value_errors + n_other + dut_i.sva_i.fail_count;
        $display("summary: %0d value errors, %0d other failures, %0d assertion failures",
                 n_value_errors, n_other, dut_i.sva_i.fail_count);
        if (total == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: tests/riscv_core_sva.sv
module riscv_core_sva (
    input logic               clk,
    input logic               rst,
    input logic               retire,
    input logic               halted,
    input logic               dmem_we,
    input rv_pkg::fsm_state_t state
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;    // read by the testbench for its summary

    retire_pulse: assert property (@(posedge clk) disable iff (rst) retire |=> !retire)
        else begin
            fail_count++;
            $error("retire stayed high for more than one cycle");
        end

    // only reset may take the core out of halt
    halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            fail_count++;
            $error("halted fell while rst was low");
        end

    store_phase: assert property (@(posedge clk) disable iff (rst)
                                  dmem_we |-> state == rv_pkg::S_MEMORY)
        else begin
            fail_count++;
            $error("dmem_we was high outside the memory phase");
        end

    legal_state: assert property (@(posedge clk) disable iff (rst)
                                  !$isunknown(state) && state inside {rv_pkg::S_IDLE,
                                  rv_pkg::S_FETCH, rv_pkg::S_DECODE, rv_pkg::S_EXECUTE,
                                  rv_pkg::S_MEMORY, rv_pkg::S_WRITEBACK, rv_pkg::S_HALT})
        else begin
            fail_count++;
            $error("FSM state left the defined encodings");
        end

endmodule

bind riscv_core riscv_core_sva sva_i (
    .clk     (clk),
    .rst     (rst),
    .retire  (retire),
    .halted  (halted),
    .dmem_we (dmem_we),
    .state   (state)
);

// File: hw/riscv_core.sv
module riscv_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       load_en,
    input  logic [rv_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]                load_data,
    output logic                       halted,
    output logic                       retire,
    output logic                       retire_we,
    output logic [31:0]                retire_pc,
    output logic [4:0]                 retire_rd,
    output logic [31:0]                retire_value
);

    rv_pkg::fsm_state_t state;
    rv_pkg::alu_op_t    alu_op;

    logic [31:0] imem_rdata;
    logic [31:0] ir;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [31:0] jump_target;
    logic [31:0] imm;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] res_q;
    logic [31:0] dmem_rdata;
    logic [31:0] wb_data;
    logic [6:0]  opcode;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [rv_pkg::IMEM_AW-1:0] fetch_addr;

    logic alu_source;
    logic alu_zero;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jump;
    logic is_jalr;
    logic is_halt;
    logic writes_rd;
    logic branch_ne;
    logic branch_taken;
    logic ir_load;
    logic opnd_load;
    logic res_load;
    logic dmem_we;
    logic rf_we;
    logic pc_step;
    logic pc_jump;
    logic load_ok;

    // ==============================
    // fetch and instruction register
    // ==============================
    // the program port is only open while nothing executes
    assign load_ok = load_en && (state == rv_pkg::S_IDLE || state == rv_pkg::S_HALT);

    // in writeback the memory already reads the next pc so that fetch sees it
    assign fetch_addr = (pc_step || pc_jump) ? next_pc[rv_pkg::IMEM_AW+1:2]
                                             : pc[rv_pkg::IMEM_AW+1:2];

    instr_mem imem_i (
        .clk       (clk),
        .load_en   (load_ok),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (fetch_addr),
        .rd_data   (imem_rdata)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
            ir <= 32'b0;             // zero decodes as a no-op
        else if (ir_load)
            ir <= imem_rdata;
    end

    instr_decoder dec_i (
        .instruction (ir),
        .opcode      (opcode),
        .funct7      (),
        .funct3      (),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_source  (alu_source),
        .alu_op      (alu_op),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .is_jalr     (is_jalr),
        .is_halt     (is_halt),
        .writes_rd   (writes_rd),
        .branch_ne   (branch_ne)
    );

    control_fsm fsm_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_branch    (is_branch),
        .is_jump      (is_jump),
        .is_halt      (is_halt),
        .branch_taken (branch_taken),
        .state        (state),
        .ir_load      (ir_load),
        .opnd_load    (opnd_load),
        .res_load     (res_load),
        .dmem_we      (dmem_we),
        .rf_we        (rf_we),
        .pc_step      (pc_step),
        .pc_jump      (pc_jump),
        .retire       (retire),
        .halted       (halted)
    );

    // ==============================
    // operands, alu and memory
    // ==============================
    reg_file rf_i (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (rf_we && writes_rd),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_ff @(posedge clk)
    begin
        if (opnd_load)
        begin
            opnd_a <= rdata1;
            opnd_b <= rdata2;
        end
        if (res_load)
            res_q <= alu_result;
    end

    assign alu_b = alu_source ? imm : opnd_b;

    alu alu_i (
        .a      (opnd_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    data_mem dmem_i (
        .clk   (clk),
        .we    (dmem_we),
        .addr  (res_q[7:2]),
        .wdata (opnd_b),
        .rdata (dmem_rdata)
    );

    // ==============================
    // pc, writeback and trace
    // ==============================
    assign branch_taken = alu_zero ^ branch_ne;    // operands stay latched through writeback
    assign pc_plus4     = pc + 32'd4;
    assign jump_target  = is_jalr ? ((opnd_a + imm) & ~32'd1) : (pc + imm);
    assign next_pc      = pc_jump ? jump_target : pc_plus4;

    pc_counter pc_i (
        .clk    (clk),
        .rst    (rst),
        .step   (pc_step),
        .jump   (pc_jump),
        .target (jump_target),
        .pc     (pc)
    );

    always_comb
    begin
        if (is_load)
            wb_data = dmem_rdata;
        else if (is_jump)
            wb_data = pc_plus4;                    // link address for jal and jalr
        else if (opcode == rv_pkg::OP_LUI)
            wb_data = imm;
        else
            wb_data = res_q;
    end

    assign retire_pc    = pc;
    assign retire_rd    = rd;
    assign retire_we    = retire && writes_rd;
    assign retire_value = wb_data;

endmodule

// File: hw/data_mem.sv
module data_mem (
    input  logic                                  clk,
    input  logic                                  we,
    input  logic [$clog2(rv_pkg::DMEM_WORDS)-1:0] addr,
    input  logic [31:0]                           wdata,
    output logic [31:0]                           rdata
);

    logic [31:0] mem [rv_pkg::DMEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

// File: hw/instr_mem.sv
module instr_mem (
    input  logic                       clk,
    input  logic                       load_en,
    input  logic [rv_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]                load_data,
    input  logic [rv_pkg::IMEM_AW-1:0] rd_addr,
    output logic [31:0]                rd_data
);

    logic [31:0] mem [rv_pkg::IMEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (load_en)
            mem[load_addr] <= load_data;
        rd_data <= mem[rd_addr];    // read data shows up one cycle after the address
    end

endmodule

// File: hw/control_fsm.sv
module control_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               is_load,
    input  logic               is_store,
    input  logic               is_branch,
    input  logic               is_jump,
    input  logic               is_halt,
    input  logic               branch_taken,
    output rv_pkg::fsm_state_t state,
    output logic               ir_load,
    output logic               opnd_load,
    output logic               res_load,
    output logic               dmem_we,
    output logic               rf_we,
    output logic               pc_step,
    output logic               pc_jump,
    output logic               retire,
    output logic               halted
);

    rv_pkg::fsm_state_t state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= rv_pkg::S_IDLE;
        else
            state <= state_next;
    end

    // ==============================
    // next state
    // ==============================
    always_comb
    begin
        state_next = state;
        case (state)
            rv_pkg::S_IDLE:
            begin
                if (start)
                    state_next = rv_pkg::S_FETCH;
            end
            rv_pkg::S_FETCH:
                state_next = rv_pkg::S_DECODE;
            rv_pkg::S_DECODE:
            begin
                if (is_halt)
                    state_next = rv_pkg::S_HALT;    // ecall stops here and never retires
                else
                    state_next = rv_pkg::S_EXECUTE;
            end
            rv_pkg::S_EXECUTE:
            begin
                if (is_load || is_store)
                    state_next = rv_pkg::S_MEMORY;
                else
                    state_next = rv_pkg::S_WRITEBACK;
            end
            rv_pkg::S_MEMORY:
                state_next = rv_pkg::S_WRITEBACK;
            rv_pkg::S_WRITEBACK:
                state_next = rv_pkg::S_FETCH;
            rv_pkg::S_HALT:
                state_next = rv_pkg::S_HALT;        // only reset leaves halt
            default:
                state_next = rv_pkg::S_IDLE;
        endcase
    end

    // ==============================
    // phase strobes
    // ==============================
    assign ir_load   = (state == rv_pkg::S_FETCH);
    assign opnd_load = (state == rv_pkg::S_DECODE);
    assign res_load  = (state == rv_pkg::S_EXECUTE);
    assign dmem_we   = (state == rv_pkg::S_MEMORY) && is_store;

    assign rf_we   = (state == rv_pkg::S_WRITEBACK);    // top level masks this with writes_rd
    assign retire  = (state == rv_pkg::S_WRITEBACK);
    assign pc_jump = (state == rv_pkg::S_WRITEBACK) && (is_jump || (is_branch && branch_taken));
    assign pc_step = (state == rv_pkg::S_WRITEBACK) && !pc_jump;
    assign halted  = (state == rv_pkg::S_HALT);

endmodule

// File: hw/pc_counter.sv
module pc_counter (
    input  logic        clk,
    input  logic        rst,
    input  logic        step,
    input  logic        jump,
    input  logic [31:0] target,
    output logic [31:0] pc
);

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= 32'b0;
        else if (jump)                // a taken jump overrides the sequential step
            pc <= target;
        else if (step)
            pc <= pc + 32'd4;
    end

endmodule

// File: hw/reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'b0;
        end
        else if (we && rd != 5'd0)
            regs[rd] <= wdata;
    end

    assign rdata1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];    // x0 always reads zero
    assign rdata2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

// File: hw/alu.sv
module alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_t op,
    output logic [31:0]     result,
    output logic            zero
);

    logic [31:0] diff;

    assign diff = a - b;

    // branches look only at this flag, so it comes from the subtract and not from result
    assign zero = (diff == 32'b0);

    always_comb
    begin
        case (op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = diff;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLL:    result = a << b[4:0];
            rv_pkg::ALU_SRL:    result = a >> b[4:0];
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = 32'b0;
        endcase
    end

endmodule

// File: hw/instr_decoder.sv
module instr_decoder (
    input  logic [31:0]     instruction,
    output logic [6:0]      opcode,
    output logic [6:0]      funct7,
    output logic [2:0]      funct3,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [31:0]     imm,
    output logic            alu_source,    // 0 means register, 1 means immediate
    output rv_pkg::alu_op_t alu_op,
    output logic            is_load,
    output logic            is_store,
    output logic            is_branch,
    output logic            is_jump,
    output logic            is_jalr,
    output logic            is_halt,
    output logic            writes_rd,
    output logic            branch_ne
);

    always_comb
    begin
        opcode     = instruction[6:0];
        funct7     = 7'b0;
        funct3     = 3'b0;
        rs1        = 5'b0;
        rs2        = 5'b0;
        rd         = 5'b0;
        imm        = 32'b0;
        alu_source = 1'b0;
        alu_op     = rv_pkg::ALU_ADD;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_branch  = 1'b0;
        is_jump    = 1'b0;
        is_jalr    = 1'b0;
        is_halt    = 1'b0;
        writes_rd  = 1'b0;
        branch_ne  = 1'b0;

        case (opcode)
            rv_pkg::OP_R, rv_pkg::OP_IMM:
            begin
                funct3    = instruction[14:12];
                rs1       = instruction[19:15];
                rd        = instruction[11:7];
                writes_rd = 1'b1;
                if (opcode == rv_pkg::OP_R)
                begin
                    funct7 = instruction[31:25];
                    rs2    = instruction[24:20];
                end
                else
                begin
                    imm        = {{20{instruction[31]}}, instruction[31:20]};
                    alu_source = 1'b1;
                end
                case (funct3)
                    3'b000:
                    begin
                        if (funct7[5])                   // only R type carries funct7 here
                            alu_op = rv_pkg::ALU_SUB;
                        else
                            alu_op = rv_pkg::ALU_ADD;
                    end
                    3'b001:  alu_op = rv_pkg::ALU_SLL;
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    3'b100:  alu_op = rv_pkg::ALU_XOR;
                    3'b101:  alu_op = rv_pkg::ALU_SRL;
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    3'b111:  alu_op = rv_pkg::ALU_AND;
                    default: alu_op = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OP_LOAD, rv_pkg::OP_JALR:
            begin
                funct3     = instruction[14:12];
                rs1        = instruction[19:15];
                rd         = instruction[11:7];
                imm        = {{20{instruction[31]}}, instruction[31:20]};
                alu_source = 1'b1;
                writes_rd  = 1'b1;
                is_load    = (opcode == rv_pkg::OP_LOAD);
                is_jump    = (opcode == rv_pkg::OP_JALR);
                is_jalr    = (opcode == rv_pkg::OP_JALR);
            end
            rv_pkg::OP_STORE:
            begin
                funct3     = instruction[14:12];
                rs1        = instruction[19:15];
                rs2        = instruction[24:20];
                imm        = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
                alu_source = 1'b1;
                is_store   = 1'b1;
            end
            rv_pkg::OP_BRANCH:
            begin
                funct3    = instruction[14:12];
                rs1       = instruction[19:15];
                rs2       = instruction[24:20];
                imm       = {{19{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
                alu_op    = rv_pkg::ALU_SUB;     // compare rs1 against rs2 through zero
                is_branch = (funct3[2:1] == 2'b00);
                branch_ne = funct3[0];
            end
            rv_pkg::OP_JAL:
            begin
                rd        = instruction[11:7];
                imm       = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
                writes_rd = 1'b1;
                is_jump   = 1'b1;
            end
            rv_pkg::OP_LUI:
            begin
                rd         = instruction[11:7];
                imm        = {instruction[31:12], 12'b0};
                alu_source = 1'b1;
                alu_op     = rv_pkg::ALU_PASS_B;
                writes_rd  = 1'b1;
            end
            rv_pkg::OP_SYSTEM:
                is_halt = (instruction[14:12] == 3'b000);
            default:
                is_halt = 1'b0;                  // anything else runs as a no-op
        endcase
    end

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

    // ==============================
    // base opcodes
    // ==============================
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // ==============================
    // memory geometry
    // ==============================
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;     // word address, byte address bits [7:2]

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    // one encoding is left over and falls back to idle
    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALT
    } fsm_state_t;

endpackage
